// ==== src/mipsPkg.sv ====
// Shared definitions for the MIPS32 instruction front end
// Opcodes, decoder enums, control word and the packets that move between stages
`default_nettype none

package mipsPkg;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type function field of JR, instr[5:0]
	localparam logic [5:0] FN_JR = 6'h08;

	// First fetch address after reset
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// Instruction queue size
	localparam int QUEUE_DEPTH = 4;
	// Enough bits to count 0 to QUEUE_DEPTH
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Free-slot count as seen by fetch
	typedef logic [QUEUE_CNT_W-1:0] queueCountT;

	// Which register gets written
	typedef enum logic [1:0] {
		DEST_RD   = 2'd0,
		DEST_RT   = 2'd1,
		DEST_RA   = 2'd2,
		DEST_NONE = 2'd3
	} regDestT;

	// Writeback source
	typedef enum logic [1:0] {
		SRC_ALU = 2'd0,
		SRC_MEM = 2'd1,
		SRC_PC4 = 2'd2
	} regSrcT;

	// How the branch target is built
	// BR_NONE also covers the 26-bit J and JAL index
	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_IMM  = 2'd1,
		BR_REG  = 2'd2
	} branchSrcT;

	// Branch condition for the later stages
	// GT and LE are reserved, nothing decodes to them yet
	typedef enum logic [2:0] {
		CMP_NONE = 3'd0,
		CMP_EQ   = 3'd1,
		CMP_NE   = 3'd2,
		CMP_GT   = 3'd3,
		CMP_LE   = 3'd4,
		CMP_JUMP = 3'd5
	} compareCodeT;

	// Control word carried to EX, MEM and WB
	typedef struct packed {
		// EX
		logic    aluSrcReg;
		regDestT regDest;
		// MEM
		logic    memRead;
		logic    memWrite;
		// WB
		logic    regWrite;
		regSrcT  regSrc;
	} controlWordT;

	// Word returned by the instruction memory plus its address
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetchPacketT;

	// Decoded operation leaving the front end
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		controlWordT control;
		logic        isJump;
		branchSrcT   branchSrc;
		compareCodeT compareCode;
		// pc+4 top nibble with index << 2, meaningful for J and JAL only
		logic [31:0] jumpTarget;
	} decodedOpT;

endpackage

`default_nettype wire

// ==== src/unitControl.sv ====
// Control decoder of the MIPS32 decode stage
// Maps opcode and function field to the control word and branch info
// Purely combinational, one instance inside decodeStage
`timescale 1ns/10ps
`default_nettype none

module unitControl (
	input  wire logic [5:0]         opcode,
	// R-type function field, instr[5:0]
	input  wire logic [5:0]         funct,
	output mipsPkg::controlWordT    controlOut,
	output logic                    isJump,
	output mipsPkg::branchSrcT      branchSrc,
	output mipsPkg::compareCodeT    compareCode
);

	always_comb begin
		// Defaults act as a NOP
		controlOut           = '0;
		controlOut.regDest   = mipsPkg::DEST_NONE;
		controlOut.regSrc    = mipsPkg::SRC_ALU;
		isJump               = 1'b0;
		branchSrc            = mipsPkg::BR_NONE;
		compareCode          = mipsPkg::CMP_NONE;

		case (opcode)
			mipsPkg::OP_RTYPE: begin
				if (funct == mipsPkg::FN_JR) begin
					// Target comes from rs, nothing written back
					isJump      = 1'b1;
					branchSrc   = mipsPkg::BR_REG;
					compareCode = mipsPkg::CMP_JUMP;
				end else begin
					controlOut.aluSrcReg = 1'b1;
					controlOut.regDest   = mipsPkg::DEST_RD;
					controlOut.regWrite  = 1'b1;
				end
			end

			mipsPkg::OP_J: begin
				// 26-bit index, BR_NONE
				isJump      = 1'b1;
				compareCode = mipsPkg::CMP_JUMP;
			end

			mipsPkg::OP_JAL: begin
				// Link address pc+4 goes to $ra
				isJump              = 1'b1;
				compareCode         = mipsPkg::CMP_JUMP;
				controlOut.regDest  = mipsPkg::DEST_RA;
				controlOut.regWrite = 1'b1;
				controlOut.regSrc   = mipsPkg::SRC_PC4;
			end

			mipsPkg::OP_ADDI, mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_SLTI: begin
				// Immediate operand, result to rt
				controlOut.regDest  = mipsPkg::DEST_RT;
				controlOut.regWrite = 1'b1;
			end

			mipsPkg::OP_BEQ: begin
				controlOut.aluSrcReg = 1'b1;
				branchSrc            = mipsPkg::BR_IMM;
				compareCode          = mipsPkg::CMP_EQ;
			end

			mipsPkg::OP_BNE: begin
				controlOut.aluSrcReg = 1'b1;
				branchSrc            = mipsPkg::BR_IMM;
				compareCode          = mipsPkg::CMP_NE;
			end

			mipsPkg::OP_LW: begin
				// Address is rs + imm, data from memory to rt
				controlOut.regDest  = mipsPkg::DEST_RT;
				controlOut.memRead  = 1'b1;
				controlOut.regWrite = 1'b1;
				controlOut.regSrc   = mipsPkg::SRC_MEM;
			end

			mipsPkg::OP_SW: begin
				controlOut.memWrite = 1'b1;
			end

			default: begin
				// Unknown opcode stays a NOP
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/instrFetch.sv ====
// Instruction fetch with a Wishbone classic master port
// One bus cycle at a time, started only when a queue slot is free
// Redirects from decode reload the pc and drop any word still in flight
`timescale 1ns/10ps
`default_nettype none

module instrFetch (
	input  wire logic                 clock,
	input  wire logic                 rst,
	// Wishbone master
	output logic                      wbCyc,
	output logic                      wbStb,
	output logic [31:0]               wbAdr,
	output logic                      wbWe,
	input  wire logic [31:0]          wbDatIn,
	input  wire logic                 wbAck,
	// Push side of the queue
	output logic                      pushValid,
	output mipsPkg::fetchPacketT      pushData,
	input  wire logic                 pushReady,
	input  wire mipsPkg::queueCountT  queueSpace,
	// From decode
	input  wire logic                 redirect,
	input  wire logic [31:0]          redirectPc
);

	typedef enum logic {
		BUS_IDLE,
		BUS_ACTIVE
	} busStateT;

	busStateT             busState;
	logic [31:0]          pc;
	logic                 stale;
	mipsPkg::fetchPacketT heldPacket;
	logic                 startCycle;
	logic                 dropWord;

	// CYC and STB move together
	assign wbCyc = (busState == BUS_ACTIVE);
	assign wbStb = (busState == BUS_ACTIVE);
	// Read-only master
	assign wbWe  = 1'b0;

	assign pushData = heldPacket;

	// A word waiting in the holding register already owns one slot
	assign startCycle = (busState == BUS_IDLE) && !redirect &&
		(queueSpace > mipsPkg::queueCountT'(pushValid));

	// Returned word is useless once a redirect has been seen
	assign dropWord = stale || redirect;

	always_ff @(posedge clock) begin
		if (rst) begin
			busState  <= BUS_IDLE;
			pc        <= mipsPkg::RESET_PC;
			stale     <= 1'b0;
			pushValid <= 1'b0;
		end else begin
			if (pushValid && pushReady) begin
				pushValid <= 1'b0;
			end

			case (busState)
				BUS_IDLE: begin
					if (startCycle) begin
						busState <= BUS_ACTIVE;
					end
				end
				BUS_ACTIVE: begin
					if (wbAck) begin
						// Bus drops for at least one cycle after the ack
						busState <= BUS_IDLE;
						stale    <= 1'b0;
						if (!dropWord) begin
							pushValid <= 1'b1;
							pc        <= pc + 32'd4;
						end
					end else if (redirect) begin
						// Let the cycle finish, discard its data
						stale <= 1'b1;
					end
				end
				default: busState <= BUS_IDLE;
			endcase

			// Redirect wins over the pc step and kills a pending push
			if (redirect) begin
				pc        <= redirectPc;
				pushValid <= 1'b0;
			end
		end
	end

	// Address and returned word
	always_ff @(posedge clock) begin
		if (startCycle) begin
			wbAdr <= pc;
		end
		if (busState == BUS_ACTIVE && wbAck) begin
			heldPacket.pc    <= wbAdr;
			heldPacket.instr <= wbDatIn;
		end
	end

	stbInsideCyc: assert property (@(posedge clock) disable iff (rst)
		wbStb |-> wbCyc)
		else $error("wbStb high without wbCyc");

	// Address may not move while the slave has not acked
	adrHeldUntilAck: assert property (@(posedge clock) disable iff (rst)
		wbStb && !wbAck |=> wbStb && $stable(wbAdr))
		else $error("Wishbone cycle changed before ack");

endmodule

`default_nettype wire

// ==== src/instrQueue.sv ====
// Small synchronous FIFO between fetch and decode
// Payload type is a parameter, flush empties it in one cycle
// queueSpace reports free slots so the producer can reserve ahead
`timescale 1ns/10ps
`default_nettype none

module instrQueue #(
	parameter type payloadT = mipsPkg::fetchPacketT,
	parameter int  DEPTH    = mipsPkg::QUEUE_DEPTH
) (
	input  wire logic                       clock,
	input  wire logic                       rst,
	input  wire logic                       flush,
	// Write side
	input  wire logic                       pushValid,
	input  wire payloadT                    pushData,
	output logic                            pushReady,
	// Read side
	output logic                            popValid,
	output payloadT                         popData,
	input  wire logic                       popReady,
	output logic [$clog2(DEPTH+1)-1:0]      queueSpace
);

	typedef logic [$clog2(DEPTH)-1:0]   ptrT;
	typedef logic [$clog2(DEPTH+1)-1:0] countT;

	payloadT mem [DEPTH];
	ptrT     wrPtr;
	ptrT     rdPtr;
	countT   count;
	logic    doPush;
	logic    doPop;

	// Wraps at DEPTH, also for depths that are not a power of two
	function automatic ptrT nextPtr(input ptrT ptr);
		return (ptr == ptrT'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pushReady  = (count != countT'(DEPTH));
	assign popValid   = (count != '0);
	assign popData    = mem[rdPtr];
	assign queueSpace = countT'(DEPTH) - count;

	assign doPush = pushValid && pushReady;
	assign doPop  = popValid && popReady;

	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (rst || flush) begin
			// A push on the flush edge is lost on purpose
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	// Producer reserves its slot before the bus cycle, so it never meets a full queue
	noPushWhenFull: assert property (@(posedge clock) disable iff (rst)
		pushValid |-> pushReady)
		else $error("Push offered while queue full");

	countInRange: assert property (@(posedge clock) disable iff (rst)
		count <= countT'(DEPTH))
		else $error("Queue count above DEPTH");

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
// Decode stage of the front end
// Pops one fetch packet at a time, runs the control decoder and
// registers the decoded op behind a valid/ready handshake
// J and JAL redirect fetch and flush the queue at the pop edge
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input  wire logic                  clock,
	input  wire logic                  rst,
	// From the queue
	input  wire logic                  popValid,
	input  wire mipsPkg::fetchPacketT  popData,
	output logic                       popReady,
	// To fetch and queue
	output logic                       redirect,
	output logic [31:0]                redirectPc,
	// Decoded output
	output logic                       opValid,
	output mipsPkg::decodedOpT         op,
	input  wire logic                  opReady
);

	mipsPkg::controlWordT controlWord;
	logic                 isJump;
	mipsPkg::branchSrcT   branchSrc;
	mipsPkg::compareCodeT compareCode;
	logic [31:0]          pcPlus4;
	logic [31:0]          jumpTarget;
	logic                 doPop;
	mipsPkg::decodedOpT   nextOp;

	unitControl uControl (
		.opcode      (popData.instr[31:26]),
		.funct       (popData.instr[5:0]),
		.controlOut  (controlWord),
		.isJump      (isJump),
		.branchSrc   (branchSrc),
		.compareCode (compareCode)
	);

	// Output register free, or being emptied this cycle
	assign popReady = !opValid || opReady;
	assign doPop    = popValid && popReady;

	// Region of pc+4 with the word index
	assign pcPlus4    = popData.pc + 32'd4;
	assign jumpTarget = {pcPlus4[31:28], popData.instr[25:0], 2'b00};

	// Only J and JAL, JR waits for the register value downstream
	assign redirect   = doPop && isJump && (branchSrc == mipsPkg::BR_NONE);
	assign redirectPc = jumpTarget;

	always_comb begin
		nextOp.pc          = popData.pc;
		nextOp.instr       = popData.instr;
		nextOp.control     = controlWord;
		nextOp.isJump      = isJump;
		nextOp.branchSrc   = branchSrc;
		nextOp.compareCode = compareCode;
		nextOp.jumpTarget  = jumpTarget;
	end

	// Valid flag
	always_ff @(posedge clock) begin
		if (rst) begin
			opValid <= 1'b0;
		end else if (doPop) begin
			opValid <= 1'b1;
		end else if (opReady) begin
			opValid <= 1'b0;
		end
	end

	// Decoded op, loaded on each pop
	always_ff @(posedge clock) begin
		if (doPop) begin
			op <= nextOp;
		end
	end

	opHeldUnderBackPressure: assert property (@(posedge clock) disable iff (rst)
		opValid && !opReady |=> opValid && $stable(op))
		else $error("Decoded op changed while stalled");

endmodule

`default_nettype wire

// ==== src/frontEnd.sv ====
// Top of the instruction front end
// Fetch feeds the queue, decode drains it, a decode redirect flushes the queue
`timescale 1ns/10ps
`default_nettype none

module frontEnd (
	input  wire logic          clock,
	input  wire logic          rst,
	// Instruction memory, Wishbone classic
	output logic               wbCyc,
	output logic               wbStb,
	output logic [31:0]        wbAdr,
	output logic               wbWe,
	input  wire logic [31:0]   wbDatIn,
	input  wire logic          wbAck,
	// Decoded operations
	output logic               opValid,
	output mipsPkg::decodedOpT op,
	input  wire logic          opReady
);

	logic                 pushValid;
	logic                 pushReady;
	mipsPkg::fetchPacketT pushData;
	logic                 popValid;
	logic                 popReady;
	mipsPkg::fetchPacketT popData;
	mipsPkg::queueCountT  queueSpace;
	logic                 redirect;
	logic [31:0]          redirectPc;

	instrFetch uFetch (
		.clock      (clock),
		.rst        (rst),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.wbAdr      (wbAdr),
		.wbWe       (wbWe),
		.wbDatIn    (wbDatIn),
		.wbAck      (wbAck),
		.pushValid  (pushValid),
		.pushData   (pushData),
		.pushReady  (pushReady),
		.queueSpace (queueSpace),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	instrQueue #(
		.payloadT (mipsPkg::fetchPacketT),
		.DEPTH    (mipsPkg::QUEUE_DEPTH)
	) uQueue (
		.clock      (clock),
		.rst        (rst),
		.flush      (redirect),
		.pushValid  (pushValid),
		.pushData   (pushData),
		.pushReady  (pushReady),
		.popValid   (popValid),
		.popData    (popData),
		.popReady   (popReady),
		.queueSpace (queueSpace)
	);

	decodeStage uDecode (
		.clock      (clock),
		.rst        (rst),
		.popValid   (popValid),
		.popData    (popData),
		.popReady   (popReady),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.opValid    (opValid),
		.op         (op),
		.opReady    (opReady)
	);

endmodule

`default_nettype wire

// ==== tb/tbFrontEnd.sv ====
// Testbench for the instruction front end
// Wishbone memory model with random latency, random opReady, and an expected op stream
// that follows J and JAL; every accepted op is compared against a reference decode
`timescale 1ns/10ps
`default_nettype none

module tbFrontEnd;

	localparam int NUM_OPS        = 80;
	localparam int TIMEOUT_CYCLES = 200 * NUM_OPS + 100;

	logic               clock;
	logic               rst;
	logic               wbCyc;
	logic               wbStb;
	logic [31:0]        wbAdr;
	logic               wbWe;
	logic [31:0]        wbDatIn;
	logic               wbAck;
	logic               opValid;
	mipsPkg::decodedOpT op;
	logic               opReady;

	logic [31:0]        imem [64];
	mipsPkg::decodedOpT expected [$];
	int                 compared       = 0;
	int                 checkErrors    = 0;
	int                 otherErrors    = 0;
	int                 cycles         = 0;
	logic               heldLast       = 1'b0;
	mipsPkg::decodedOpT heldOp;
	logic               firstFetchSeen = 1'b0;
	logic               resetSeen      = 1'b0;

	frontEnd u_dut (
		.clock   (clock),
		.rst     (rst),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbAdr   (wbAdr),
		.wbWe    (wbWe),
		.wbDatIn (wbDatIn),
		.wbAck   (wbAck),
		.opValid (opValid),
		.op      (op),
		.opReady (opReady)
	);

	function automatic logic [31:0] encodeI(input logic [5:0] opc, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	// Jump index is the target word address
	function automatic logic [31:0] encodeJ(input logic [5:0] opc, input int wordAddr);
		return {opc, 26'(wordAddr)};
	endfunction

	// Expected decode of one instruction from the decoder table
	function automatic mipsPkg::decodedOpT decodeRef(input logic [31:0] pc,
		input logic [31:0] instr);
		mipsPkg::decodedOpT d;
		logic [31:0]        nextPc;
		nextPc                = pc + 32'd4;
		d                     = '0;
		d.pc                  = pc;
		d.instr               = instr;
		d.control.regDest     = mipsPkg::DEST_NONE;
		d.control.regSrc      = mipsPkg::SRC_ALU;
		d.branchSrc           = mipsPkg::BR_NONE;
		d.compareCode         = mipsPkg::CMP_NONE;
		d.jumpTarget          = {nextPc[31:28], instr[25:0], 2'b00};
		case (instr[31:26])
			mipsPkg::OP_RTYPE: begin
				if (instr[5:0] == mipsPkg::FN_JR) begin
					d.isJump      = 1'b1;
					d.branchSrc   = mipsPkg::BR_REG;
					d.compareCode = mipsPkg::CMP_JUMP;
				end else begin
					d.control.regDest   = mipsPkg::DEST_RD;
					d.control.regWrite  = 1'b1;
					d.control.aluSrcReg = 1'b1;
				end
			end
			mipsPkg::OP_J: begin
				d.isJump      = 1'b1;
				d.compareCode = mipsPkg::CMP_JUMP;
			end
			mipsPkg::OP_JAL: begin
				d.isJump           = 1'b1;
				d.compareCode      = mipsPkg::CMP_JUMP;
				d.control.regDest  = mipsPkg::DEST_RA;
				d.control.regWrite = 1'b1;
				d.control.regSrc   = mipsPkg::SRC_PC4;
			end
			mipsPkg::OP_ADDI, mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_SLTI: begin
				d.control.regDest  = mipsPkg::DEST_RT;
				d.control.regWrite = 1'b1;
			end
			mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
				d.control.aluSrcReg = 1'b1;
				d.branchSrc         = mipsPkg::BR_IMM;
				d.compareCode       = (instr[31:26] == mipsPkg::OP_BEQ) ?
					mipsPkg::CMP_EQ : mipsPkg::CMP_NE;
			end
			mipsPkg::OP_LW: begin
				d.control.regDest  = mipsPkg::DEST_RT;
				d.control.memRead  = 1'b1;
				d.control.regWrite = 1'b1;
				d.control.regSrc   = mipsPkg::SRC_MEM;
			end
			mipsPkg::OP_SW: d.control.memWrite = 1'b1;
			default: ;
		endcase
		return d;
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < 64; i++) begin
			// Filler that must never show up is tagged with its own address
			imem[i] = encodeI(mipsPkg::OP_ORI, 5'd3, 5'd4, 16'(i * 4) ^ 16'h5a00);
		end
		imem[0]  = encodeI(mipsPkg::OP_ADDI, 5'd1, 5'd2, 16'h0010);
		imem[1]  = encodeI(mipsPkg::OP_ANDI, 5'd2, 5'd3, 16'h00ff);
		imem[2]  = encodeI(mipsPkg::OP_ORI, 5'd3, 5'd4, 16'h1234);
		imem[3]  = encodeI(mipsPkg::OP_SLTI, 5'd4, 5'd5, 16'hfff0);
		imem[4]  = encodeR(5'd1, 5'd2, 5'd6, 6'h20);
		imem[5]  = encodeR(5'd31, 5'd0, 5'd0, mipsPkg::FN_JR);
		imem[6]  = encodeI(mipsPkg::OP_BEQ, 5'd1, 5'd2, 16'h0004);
		imem[7]  = encodeI(mipsPkg::OP_BNE, 5'd3, 5'd4, 16'hfffc);
		imem[8]  = encodeI(mipsPkg::OP_LW, 5'd29, 5'd7, 16'h0008);
		imem[9]  = encodeI(mipsPkg::OP_SW, 5'd29, 5'd7, 16'h000c);
		// Unknown opcode decodes as a NOP
		imem[10] = {6'h3f, 26'h12_3456};
		imem[11] = encodeJ(mipsPkg::OP_J, 20);
		imem[20] = encodeI(mipsPkg::OP_ADDI, 5'd8, 5'd9, 16'h0001);
		imem[21] = encodeJ(mipsPkg::OP_JAL, 40);
		imem[40] = encodeR(5'd9, 5'd8, 5'd10, 6'h22);
		imem[41] = encodeI(mipsPkg::OP_LW, 5'd10, 5'd11, 16'h0010);
		imem[42] = encodeJ(mipsPkg::OP_J, 50);
		imem[50] = encodeI(mipsPkg::OP_SW, 5'd10, 5'd11, 16'h0014);
		imem[51] = encodeI(mipsPkg::OP_ADDI, 5'd11, 5'd12, 16'h0002);
		// Jump back to the start so the run loops until NUM_OPS ops are seen
		imem[52] = encodeJ(mipsPkg::OP_J, 0);
	endtask

	// Walks the program like the front end should with no delay slot after a jump
	task automatic buildExpected();
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] nextPc;
		pc = mipsPkg::RESET_PC;
		for (int i = 0; i < NUM_OPS; i++) begin
			instr  = imem[pc[7:2]];
			nextPc = pc + 32'd4;
			expected.push_back(decodeRef(pc, instr));
			if (instr[31:26] == mipsPkg::OP_J || instr[31:26] == mipsPkg::OP_JAL) begin
				pc = {nextPc[31:28], instr[25:0], 2'b00};
			end else begin
				pc = nextPc;
			end
		end
	endtask

	task automatic checkPc(input string name, input logic [31:0] expPc,
		input logic [31:0] actPc);
		if (actPc !== expPc) begin
			checkErrors++;
			$display("CHECK FAILED %s: expected %h actual %h", name, expPc, actPc);
		end
	endtask

	task automatic checkOp(input string name, input mipsPkg::decodedOpT expOp,
		input mipsPkg::decodedOpT actOp);
		if (actOp !== expOp) begin
			checkErrors++;
			$display("CHECK FAILED %s: expected %h actual %h", name, expOp, actOp);
			$display("  control word expected %h actual %h", expOp.control, actOp.control);
		end
	endtask

	initial begin : clockGen
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Wishbone slave that acks after 0 to 3 idle cycles
	initial begin : memorySlave
		int delay;
		wbAck   = 1'b0;
		wbDatIn = '0;
		forever begin
			@(negedge clock);
			if (wbStb) begin
				delay = $urandom % 4;
				repeat (delay) @(negedge clock);
				wbDatIn = imem[wbAdr[7:2]];
				wbAck   = 1'b1;
				@(negedge clock);
				wbAck   = 1'b0;
			end
		end
	end

	initial begin : readyDriver
		opReady = 1'b0;
		forever begin
			@(negedge clock);
			// About one cycle in four stalls the output
			opReady = ($urandom % 4) != 0;
		end
	end

	// Samples pre-edge values since inputs only move on the falling edge
	always @(posedge clock) begin : compareOps
		mipsPkg::decodedOpT expOp;
		if (rst) begin
			if (resetSeen && (opValid || wbCyc)) begin
				otherErrors++;
				$display("ERROR: opValid or wbCyc high during reset");
			end
			resetSeen = 1'b1;
		end else begin
			if (!firstFetchSeen && wbCyc) begin
				firstFetchSeen = 1'b1;
				checkPc("first fetch address", mipsPkg::RESET_PC, wbAdr);
			end
			if (wbCyc && wbWe) begin
				otherErrors++;
				$display("ERROR: write cycle on the instruction port");
			end
			if (wbStb !== wbCyc) begin
				otherErrors++;
				$display("ERROR: wbStb and wbCyc do not move together");
			end
			if (heldLast) begin
				if (!opValid) begin
					otherErrors++;
					$display("ERROR: opValid dropped while the op was held");
				end else begin
					checkOp("op held under back-pressure", heldOp, op);
				end
			end
			if (opValid && opReady && compared < NUM_OPS) begin
				expOp = expected.pop_front();
				checkPc($sformatf("pc of op %0d", compared), expOp.pc, op.pc);
				checkOp($sformatf("op %0d", compared), expOp, op);
				compared++;
			end
			heldLast = opValid && !opReady;
			heldOp   = op;
		end
	end

	always @(posedge clock) begin : watchdog
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: timeout after %0d cycles, %0d of %0d ops seen",
				cycles, compared, NUM_OPS);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin : mainSequence
		void'($urandom(32'h73f6_f189));
		rst = 1'b1;
		loadProgram();
		buildExpected();
		repeat (5) @(negedge clock);
		rst = 1'b0;
		while (compared < NUM_OPS) @(negedge clock);
		$display("Done: %0d ops checked, %0d value mismatches, %0d other errors",
			compared, checkErrors, otherErrors);
		if (checkErrors + otherErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/mipsPkg.sv
src/unitControl.sv
src/instrFetch.sv
src/instrQueue.sv
src/decodeStage.sv
src/frontEnd.sv
tb/tbFrontEnd.sv

// ==== Makefile ====
# Verilator simulation of the instruction front end

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbFrontEnd -f src.f -o simFrontEnd
	@out="$$(./obj_dir/simFrontEnd)"; echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
